//--- src/mem_defs.svh
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// Geometry of the 128 x 46 user-area memory

// Full word seen by the controller
`define MEM_DATA_WIDTH 46

// Word address, 128 entries
`define MEM_ADDR_WIDTH 7

// Width of one hard macro
`define MEM_TILE_WIDTH 8

// Macros side by side, the last one only partly used
`define MEM_NUM_TILES 6

`endif

//--- src/mem_geom_pkg.sv
`include "mem_defs.svh"

package mem_geom_pkg;

  // Word address into the array
  typedef logic [`MEM_ADDR_WIDTH-1:0] addr_t;

  // Full data word
  typedef logic [`MEM_DATA_WIDTH-1:0] word_t;

  // Byte slice handled by one macro
  typedef logic [`MEM_TILE_WIDTH-1:0] tile_t;

  // One bit per macro, 1 means write that macro
  typedef logic [`MEM_NUM_TILES-1:0] mask_t;

  localparam int MEM_DEPTH = 1 << `MEM_ADDR_WIDTH;  // 128 words

endpackage

//--- src/mem_cmd_pkg.sv
`include "mem_defs.svh"

package mem_cmd_pkg;

  // Command strobe opcodes
  typedef enum logic [1:0] {
    CMD_NOP   = 2'b00,  // No effect
    CMD_READ  = 2'b01,  // Data back one cycle later
    CMD_WRITE = 2'b10,  // Masked write
    CMD_CLEAR = 2'b11   // Zero the whole array
  } cmd_op_t;

endpackage

//--- src/sram_128x8_model.sv
`timescale 1ns/10ps
`include "mem_defs.svh"

// Behavioral stand-in for the 128x8 hard macro
module sram_128x8_model
  import mem_geom_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       ce_n_i,   // Active low chip enable
  input  logic                       we_n_i,   // Active low write enable
  input  logic [`MEM_TILE_WIDTH-1:0] wmask_i,  // Per-bit write mask
  input  addr_t                      addr_i,
  input  tile_t                      wd_i,
  output tile_t                      rd_o
);

  tile_t mem_q [MEM_DEPTH];

  logic wr_en;
  logic rd_en;

  assign wr_en = !ce_n_i && !we_n_i;
  assign rd_en = !ce_n_i && we_n_i;

  // Bit-masked write
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_q[addr_i] <= (mem_q[addr_i] & ~wmask_i) | (wd_i & wmask_i);
    end
  end

  // Read data is registered and held until the next read
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rd_o <= mem_q[addr_i];
    end
  end

  // An unknown enable would corrupt the macro state silently
  ce_n_known_a: assert property (@(posedge clk_i) !$isunknown(ce_n_i))
    else $error("sram_128x8_model: ce_n_i unknown at clock edge");

endmodule

//--- src/hard_mem_1rw_wrapper.sv
`timescale 1ns/10ps
`include "mem_defs.svh"

// Six 128x8 macros tiled into one 46-bit word with a byte write mask
module hard_mem_1rw_wrapper
  import mem_geom_pkg::*;
(
  input  logic  clk_i,
  input  logic  v_i,           // Access this cycle
  input  logic  w_i,           // Write when set, read otherwise
  input  addr_t addr_i,
  input  mask_t write_mask_i,  // One bit per macro
  input  word_t data_i,
  output word_t data_o
);

  // Bits that land in the last, narrow macro
  localparam int TOP_LSB  = (`MEM_NUM_TILES - 1) * `MEM_TILE_WIDTH;
  localparam int TOP_BITS = `MEM_DATA_WIDTH - TOP_LSB;

  logic ce_n;
  logic we_n;

  tile_t wd_tile [`MEM_NUM_TILES];
  tile_t rd_tile [`MEM_NUM_TILES];

  // Macro enables are active low
  assign ce_n = ~v_i;
  assign we_n = ~w_i;

  for (genvar t = 0; t < `MEM_NUM_TILES; t++) begin : g_tile
    if (t < `MEM_NUM_TILES - 1) begin : g_full
      assign wd_tile[t] = data_i[t*`MEM_TILE_WIDTH +: `MEM_TILE_WIDTH];
      assign data_o[t*`MEM_TILE_WIDTH +: `MEM_TILE_WIDTH] = rd_tile[t];
    end else begin : g_top
      // Upper two bits tied low, readback ignored
      assign wd_tile[t] = {{(`MEM_TILE_WIDTH - TOP_BITS){1'b0}},
                           data_i[`MEM_DATA_WIDTH-1:TOP_LSB]};
      assign data_o[`MEM_DATA_WIDTH-1:TOP_LSB] = rd_tile[t][TOP_BITS-1:0];
    end

    sram_128x8_model u_sram (
      .clk_i   (clk_i),
      .ce_n_i  (ce_n),
      .we_n_i  (we_n),
      .wmask_i ({`MEM_TILE_WIDTH{write_mask_i[t]}}),  // Byte mask to bit mask
      .addr_i  (addr_i),
      .wd_i    (wd_tile[t]),
      .rd_o    (rd_tile[t])
    );
  end

endmodule

//--- src/mem_cmd_ctrl.sv
`timescale 1ns/10ps

// Command front end for the tiled memory
// Read and write pass straight to the port, a clear sweeps all addresses
module mem_cmd_ctrl
  import mem_geom_pkg::*;
  import mem_cmd_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  logic    req_v_i,
  input  cmd_op_t req_op_i,
  input  addr_t   req_addr_i,
  input  mask_t   req_mask_i,
  input  word_t   req_data_i,
  input  word_t   mem_rdata_i,
  output logic    mem_v_o,
  output logic    mem_w_o,
  output addr_t   mem_addr_o,
  output mask_t   mem_mask_o,
  output word_t   mem_data_o,
  output logic    rvalid_o,
  output word_t   rdata_o,
  output logic    busy_o,
  output logic    cmd_drop_o
);

  logic  busy_q;
  addr_t clr_addr_q;
  logic  rvalid_q;
  logic  drop_q;

  logic accept;
  logic rd_acc;
  logic wr_acc;
  logic clr_acc;
  logic last_clr;

  // Nothing is accepted during a sweep
  assign accept   = req_v_i && !busy_q;
  assign rd_acc   = accept && (req_op_i == CMD_READ);
  assign wr_acc   = accept && (req_op_i == CMD_WRITE);
  assign clr_acc  = accept && (req_op_i == CMD_CLEAR);
  assign last_clr = busy_q && (clr_addr_q == addr_t'(MEM_DEPTH - 1));

  // Sweep owns the port while busy
  always_comb begin
    if (busy_q) begin
      mem_v_o    = 1'b1;
      mem_w_o    = 1'b1;
      mem_addr_o = clr_addr_q;
      mem_mask_o = '1;  // All tiles
      mem_data_o = '0;
    end else begin
      mem_v_o    = rd_acc || wr_acc;
      mem_w_o    = wr_acc;
      mem_addr_o = req_addr_i;
      mem_mask_o = req_mask_i;
      mem_data_o = req_data_i;
    end
  end

  // Clear sequencer
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q     <= 1'b0;
      clr_addr_q <= '0;
    end else begin
      if (clr_acc) begin
        busy_q <= 1'b1;
      end else if (last_clr) begin
        busy_q <= 1'b0;  // Count wraps to zero here
      end
      if (busy_q) begin
        clr_addr_q <= clr_addr_q + 1'b1;
      end
    end
  end

  // Read return flag and drop report
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
      drop_q   <= 1'b0;
    end else begin
      rvalid_q <= rd_acc;
      drop_q   <= req_v_i && busy_q;
    end
  end

  assign busy_o     = busy_q;
  assign rvalid_o   = rvalid_q;
  assign rdata_o    = mem_rdata_i;  // Macro output already registered
  assign cmd_drop_o = drop_q;

  // A read return never overlaps a sweep
  no_rvalid_in_sweep_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) !(rvalid_o && busy_o))
    else $error("mem_cmd_ctrl: rvalid_o high during clear");

  drop_after_busy_strobe_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) cmd_drop_o |-> $past(req_v_i && busy_o))
    else $error("mem_cmd_ctrl: cmd_drop_o without a dropped strobe");

  // Sweep keeps writing the port until the last address
  sweep_drives_port_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (busy_o && !last_clr) |=> (mem_v_o && mem_w_o))
    else $error("mem_cmd_ctrl: idle memory port during clear");

endmodule

//--- src/mem_subsys_top.sv
`timescale 1ns/10ps

// 128 x 46 memory subsystem, command controller in front of the tiled macros
module mem_subsys_top
  import mem_geom_pkg::*;
  import mem_cmd_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  logic    req_v_i,     // One-cycle command strobe
  input  cmd_op_t req_op_i,
  input  addr_t   req_addr_i,
  input  mask_t   req_mask_i,
  input  word_t   req_data_i,
  output logic    rvalid_o,
  output word_t   rdata_o,
  output logic    busy_o,      // Clear in progress
  output logic    cmd_drop_o
);

  logic  mem_v;
  logic  mem_w;
  addr_t mem_addr;
  mask_t mem_mask;
  word_t mem_wdata;
  word_t mem_rdata;

  mem_cmd_ctrl u_ctrl (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_v_i     (req_v_i),
    .req_op_i    (req_op_i),
    .req_addr_i  (req_addr_i),
    .req_mask_i  (req_mask_i),
    .req_data_i  (req_data_i),
    .mem_rdata_i (mem_rdata),
    .mem_v_o     (mem_v),
    .mem_w_o     (mem_w),
    .mem_addr_o  (mem_addr),
    .mem_mask_o  (mem_mask),
    .mem_data_o  (mem_wdata),
    .rvalid_o    (rvalid_o),
    .rdata_o     (rdata_o),
    .busy_o      (busy_o),
    .cmd_drop_o  (cmd_drop_o)
  );

  hard_mem_1rw_wrapper u_mem (
    .clk_i        (clk_i),
    .v_i          (mem_v),
    .w_i          (mem_w),
    .addr_i       (mem_addr),
    .write_mask_i (mem_mask),
    .data_i       (mem_wdata),
    .data_o       (mem_rdata)
  );

endmodule

//--- verif/mem_subsys_tb.sv
`timescale 1ns/10ps
`include "mem_defs.svh"

// Pattern-driven testbench for the 128 x 46 memory subsystem
module mem_subsys_tb
  import mem_geom_pkg::*;
  import mem_cmd_pkg::*;
();

  localparam int SWEEP_LIMIT = 200;  // Cycles before a clear counts as hung
  localparam int DRAIN_LIMIT = 8;
  localparam int DROP_AT     = 40;   // Sweep cycle that gets an extra strobe, past swept words

  logic    clk_i = 1'b0;
  logic    rst_n_i;
  logic    req_v_i;
  cmd_op_t req_op_i;
  addr_t   req_addr_i;
  mask_t   req_mask_i;
  word_t   req_data_i;
  logic    rvalid_o;
  word_t   rdata_o;
  logic    busy_o;
  logic    cmd_drop_o;

  word_t shadow [MEM_DEPTH];  // Reference contents
  int    rd_cyc_q [$];        // Edge where each read is sampled
  word_t rd_word_q [$];       // Word each read must return
  int    cyc       = 0;
  int    drop_cyc  = -1;      // Edge of the one strobe that must be dropped
  bit    abort     = 1'b0;
  int    err_data  = 0;
  int    err_ctrl  = 0;
  int    err_ref   = 0;
  int    err_other = 0;

  mem_subsys_top DUT (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_v_i    (req_v_i),
    .req_op_i   (req_op_i),
    .req_addr_i (req_addr_i),
    .req_mask_i (req_mask_i),
    .req_data_i (req_data_i),
    .rvalid_o   (rvalid_o),
    .rdata_o    (rdata_o),
    .busy_o     (busy_o),
    .cmd_drop_o (cmd_drop_o)
  );

  always #4 clk_i = ~clk_i;  // 8 ns period

  always @(posedge clk_i) cyc <= cyc + 1;

  // Read returns and drop pulses, sampled mid-cycle
  always @(negedge clk_i) begin : monitor
    bit exp_rv;
    if (rst_n_i) begin
      exp_rv = (rd_cyc_q.size() > 0) && (rd_cyc_q[0] == cyc);
      assert (rvalid_o == exp_rv) else begin
        err_ctrl++;
        $display("CHECK FAILED @%0t: rvalid_o is %b, expected %b", $time, rvalid_o, exp_rv);
      end
      if (exp_rv) begin
        assert (rdata_o === rd_word_q[0]) else begin
          err_data++;
          $display("CHECK FAILED @%0t: rdata_o is %h, expected %h",
                   $time, rdata_o, rd_word_q[0]);
        end
        void'(rd_cyc_q.pop_front());
        void'(rd_word_q.pop_front());
      end
      assert (cmd_drop_o == (cyc == drop_cyc)) else begin
        err_ctrl++;
        $display("CHECK FAILED @%0t: cmd_drop_o is %b, expected %b",
                 $time, cmd_drop_o, cyc == drop_cyc);
      end
    end
  end

  task automatic next_cycle();
    @(posedge clk_i);
    #1;  // Inputs change just after the edge
  endtask

  task automatic set_req(logic v, cmd_op_t op, addr_t a, mask_t m, word_t d);
    req_v_i    = v;
    req_op_i   = op;
    req_addr_i = a;
    req_mask_i = m;
    req_data_i = d;
  endtask

  // One mask bit per 8-bit tile, top tile holds bits 45..40
  function automatic word_t apply_write(word_t old, mask_t m, word_t d);
    word_t res;
    res = old;
    for (int i = 0; i < `MEM_DATA_WIDTH; i++) begin
      if (m[i / `MEM_TILE_WIDTH]) begin
        res[i] = d[i];
      end
    end
    return res;
  endfunction

  // Clear, with one write strobe thrown in mid-sweep
  task automatic run_clear(addr_t a, mask_t m, word_t d);
    int cnt;
    cnt = 0;
    set_req(1'b1, CMD_CLEAR, '0, '0, '0);
    next_cycle();
    set_req(1'b0, CMD_NOP, '0, '0, '0);
    while (busy_o === 1'b1 && !abort) begin
      cnt++;
      if (cnt == DROP_AT) begin
        set_req(1'b1, CMD_WRITE, a, m, d);
        drop_cyc = cyc + 1;
      end else begin
        set_req(1'b0, CMD_NOP, '0, '0, '0);
      end
      next_cycle();
      if (cnt >= SWEEP_LIMIT) begin
        $display("Timeout: busy_o still high %0d cycles after a clear", cnt);
        err_other++;
        abort = 1'b1;
      end
    end
    set_req(1'b0, CMD_NOP, '0, '0, '0);
    for (int i = 0; i < MEM_DEPTH; i++) begin
      shadow[i] = '0;
    end
    if (!abort) begin
      assert (cnt == MEM_DEPTH) else begin
        err_ctrl++;
        $display("CHECK FAILED @%0t: busy_o high for %0d cycles, expected %0d",
                 $time, cnt, MEM_DEPTH);
      end
    end
  endtask

  task automatic issue_cmd(cmd_op_t op, addr_t a, mask_t m, word_t d);
    if (op == CMD_CLEAR) begin
      run_clear(a, m, d);
    end else begin
      if (op == CMD_READ) begin
        rd_cyc_q.push_back(cyc + 1);
        rd_word_q.push_back(shadow[a]);
      end else if (op == CMD_WRITE) begin
        shadow[a] = apply_write(shadow[a], m, d);
      end
      set_req(1'b1, op, a, m, d);
      next_cycle();
      set_req(1'b0, CMD_NOP, '0, '0, '0);
    end
  endtask

  task automatic run_patterns();
    int         fd;
    int         n;
    int         lineno;
    int         gap;
    string      line;
    logic [1:0] op_raw;
    addr_t      a;
    mask_t      m;
    word_t      d;
    word_t      exp_w;
    cmd_op_t    op;
    cmd_op_t    prev_op;
    fd = $fopen("verif/mem_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open the pattern file verif/mem_patterns.txt");
      err_other++;
      abort = 1'b1;
      return;
    end
    prev_op = CMD_NOP;
    lineno  = 0;
    while (!abort && $fgets(line, fd) > 0) begin
      lineno++;
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%h %h %h %h %h", op_raw, a, m, d, exp_w);
      if (n != 5) begin
        $display("Pattern file line %0d could not be parsed", lineno);
        err_other++;
        continue;
      end
      op = cmd_op_t'(op_raw);
      // Consecutive reads go out back to back
      if (!(op == CMD_READ && prev_op == CMD_READ)) begin
        gap = $urandom_range(3, 0);
        repeat (gap) next_cycle();
      end
      issue_cmd(op, a, m, d);
      assert (shadow[a] === exp_w) else begin
        err_ref++;
        $display("CHECK FAILED @%0t: line %0d expects %h at %h, reference holds %h",
                 $time, lineno, exp_w, a, shadow[a]);
      end
      prev_op = op;
    end
    $fclose(fd);
  endtask

  task automatic drain_reads();
    int waited;
    waited = 0;
    while (rd_cyc_q.size() > 0 && !abort) begin
      next_cycle();
      waited++;
      if (waited >= DRAIN_LIMIT) begin
        $display("Timeout: read returns still outstanding at the end of the run");
        err_other++;
        abort = 1'b1;
      end
    end
  endtask

  initial begin : main
    int total;
    void'($urandom(32'hb644_aa91));
    rst_n_i = 1'b0;
    set_req(1'b0, CMD_NOP, '0, '0, '0);
    repeat (2) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    assert (busy_o === 1'b0 && rvalid_o === 1'b0 && cmd_drop_o === 1'b0) else begin
      err_ctrl++;
      $display("CHECK FAILED @%0t: outputs not idle after reset", $time);
    end
    next_cycle();
    run_patterns();
    drain_reads();
    total = err_data + err_ctrl + err_ref + err_other;
    $display("Errors: data %0d, control %0d, reference %0d, other %0d",
             err_data, err_ctrl, err_ref, err_other);
    if (total == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- verif/mem_patterns.txt
# Columns op addr mask data expected in hex
# Expected is the word at addr once the command has run
# Clear lines hold the write strobe sent during the sweep
3 05 3f 3fffffffffff 000000000000
1 05 00 000000000000 000000000000
1 00 00 000000000000 000000000000
1 7f 00 000000000000 000000000000
# Full-mask writes and readback
2 10 3f 123456789abc 123456789abc
1 10 00 000000000000 123456789abc
2 7f 3f 3fffffffffff 3fffffffffff
1 7f 00 000000000000 3fffffffffff
2 00 3f 2aaaaaaaaaaa 2aaaaaaaaaaa
1 00 00 000000000000 2aaaaaaaaaaa
2 40 3f 0123456789ab 0123456789ab
2 41 3f 3edcba987654 3edcba987654
# Partial masks, top tile first
2 10 20 3fffffffffff 3f3456789abc
1 10 00 000000000000 3f3456789abc
2 10 01 0000000000ff 3f3456789aff
1 10 00 000000000000 3f3456789aff
2 10 0c 111111111111 3f3411119aff
1 10 00 000000000000 3f3411119aff
2 7f 00 000000000000 3fffffffffff
2 7f 20 000000000000 00ffffffffff
1 7f 00 000000000000 00ffffffffff
2 00 1e 155555555555 2a55555555aa
1 00 00 000000000000 2a55555555aa
# Nops, then reads back to back
0 10 3f 3fffffffffff 3f3411119aff
0 00 00 000000000000 2a55555555aa
1 10 00 000000000000 3f3411119aff
1 7f 00 000000000000 00ffffffffff
1 40 00 000000000000 0123456789ab
1 41 00 000000000000 3edcba987654
1 00 00 000000000000 2a55555555aa
# Second clear over live data
3 10 3f 3fffffffffff 000000000000
1 10 00 000000000000 000000000000
1 00 00 000000000000 000000000000
1 7f 00 000000000000 000000000000
1 40 00 000000000000 000000000000
1 41 00 000000000000 000000000000
2 7f 21 3c00000000a5 3c00000000a5
1 7f 00 000000000000 3c00000000a5
0 7f 00 000000000000 3c00000000a5

//--- compile.f
+incdir+src
src/mem_geom_pkg.sv
src/mem_cmd_pkg.sv
src/sram_128x8_model.sv
src/hard_mem_1rw_wrapper.sv
src/mem_cmd_ctrl.sv
src/mem_subsys_top.sv
verif/mem_subsys_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the memory subsystem testbench with Verilator and run it
# Exit status is nonzero unless the run reports a pass

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f compile.f \
  --top-module mem_subsys_tb \
  -o mem_sim &&
  ./obj_dir/mem_sim | tee /dev/stderr | grep -q "^Test passed$" &&
  echo "run_sim: simulation PASS" ||
  { echo "run_sim: simulation FAIL"; exit 1; }
